//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////

   // Instruction word or byte address
   typedef logic [15:0] word_t;

   // Register number, eight registers
   typedef logic [2:0] reg_t;

   // Instruction memory geometry
   localparam int mem_depth  = 256;
   localparam int mem_addr_w = $clog2(mem_depth);
   typedef logic [mem_addr_w-1:0] mem_addr_t;

   ////////////////////////////////////////
   // Opcode classes
   ////////////////////////////////////////

   // Full five-bit opcode of halt
   localparam logic [4:0] op_halt      = 5'b00000;
   // Three-bit classes, opcode bits 4:2
   localparam logic [2:0] cls_none     = 3'b000;
   localparam logic [2:0] cls_jump     = 3'b001;
   localparam logic [2:0] cls_branch   = 3'b011;
   localparam logic [2:0] cls_alu_rr   = 3'b111;
   // Four-bit class with a second source, opcode bits 4:1
   localparam logic [3:0] cls_rr_shift = 4'b1101;

   // Nop sent down the pipe in place of a word
   localparam word_t bubble_word = 16'h0800;

   // Past decode destinations kept for hazard checks
   localparam int hazard_window = 3;
   // Bubbles after a jump or branch
   localparam int shadow_len    = 2;
   // Edges from halt issue to dump
   localparam int dump_delay    = 5;

   typedef enum logic [1:0] {
      st_run,
      st_shadow1,
      st_shadow2,
      st_halted
   } fetch_state_t;

   // Stage register toward decode
   typedef struct packed {
      word_t instr;
      word_t pc_next;
   } issue_t;

   // Sources of the fetched word
   typedef struct packed {
      reg_t src_a;
      reg_t src_b;
      logic src_a_valid;
      logic src_b_valid;
   } raw_query_t;

   // Destination of the word in decode
   typedef struct packed {
      reg_t dst;
      logic valid;
   } dst_t;

endpackage

`default_nettype wire

//--- instr_mem.sv
`timescale 1ns/1ns
`default_nettype none

module instr_mem (
   input  logic                 clk,
   input  fetch_pkg::word_t     pc,
   output fetch_pkg::word_t     fetch_word,
   input  logic                 prog_we,
   input  fetch_pkg::mem_addr_t prog_addr,
   input  fetch_pkg::word_t     prog_data
);

   import fetch_pkg::*;

   // Word storage, no reset so a loaded program survives
   word_t mem [mem_depth];

   // Byte address to word index
   mem_addr_t rd_addr;

   assign rd_addr = pc[mem_addr_w:1];

   ////////////////////////////////////////
   // Read port
   ////////////////////////////////////////

   // Asynchronous, same cycle as pc
   assign fetch_word = mem[rd_addr];

   ////////////////////////////////////////
   // Load port
   ////////////////////////////////////////

   // Takes effect at the next edge
   always_ff @(posedge clk) begin
      if (prog_we) begin
         mem[prog_addr] <= prog_data;
      end
   end

endmodule

`default_nettype wire

//--- raw_detector.sv
`timescale 1ns/1ns
`default_nettype none

module raw_detector (
   input  logic                  clk,
   input  logic                  reset,
   input  fetch_pkg::raw_query_t query,
   input  fetch_pkg::dst_t       dec_dst,
   output logic                  raw
);

   import fetch_pkg::*;

   // Older decode destinations, index 0 is the newest
   dst_t hist [hazard_window];

   // Live entry plus history, as one window
   dst_t window [hazard_window+1];

   // Per-entry hits for each source
   logic [hazard_window:0] hit_a;
   logic [hazard_window:0] hit_b;

   ////////////////////////////////////////
   // Destination history
   ////////////////////////////////////////

   // Shifts every cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < hazard_window; i++) begin
            hist[i] <= '0;
         end
      end else begin
         hist[0] <= dec_dst;
         for (int i = 1; i < hazard_window; i++) begin
            hist[i] <= hist[i-1];
         end
      end
   end

   ////////////////////////////////////////
   // Source comparison
   ////////////////////////////////////////

   always_comb begin
      // Current decode destination first
      window[0] = dec_dst;
      for (int i = 0; i < hazard_window; i++) begin
         window[i+1] = hist[i];
      end
   end

   always_comb begin
      for (int i = 0; i <= hazard_window; i++) begin
         // Only valid entries can collide
         hit_a[i] = window[i].valid && (window[i].dst == query.src_a);
         hit_b[i] = window[i].valid && (window[i].dst == query.src_b);
      end
   end

   // Any valid source matching any valid entry
   assign raw = (query.src_a_valid && (|hit_a)) ||
                (query.src_b_valid && (|hit_b));

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
   input  logic                  clk,
   input  logic                  reset,
   input  fetch_pkg::word_t      fetch_word,
   output fetch_pkg::word_t      pc,
   output fetch_pkg::raw_query_t query,
   input  logic                  raw,
   input  logic                  redirect,
   input  fetch_pkg::word_t      redirect_pc,
   output fetch_pkg::issue_t     issue,
   output logic                  dump
);

   import fetch_pkg::*;

   // First state after a jump or branch, chain length follows shadow_len
   localparam fetch_state_t shadow_entry = (shadow_len >= 2) ? st_shadow1 :
                                           (shadow_len == 1) ? st_shadow2 : st_run;

   // PC and its successor
   word_t pc_q;
   word_t pc_plus2;
   word_t pc_d;

   // Fetch FSM
   fetch_state_t state;
   fetch_state_t state_d;

   // Opcode classification of the fetched word
   logic [4:0] opcode;
   logic       is_halt;
   logic       is_ctrl;

   // Word actually sent this cycle
   logic advance;
   logic halt_issue;
   issue_t issue_d;

   // Halt event delay line
   logic [dump_delay-1:0] halt_line;

   assign pc       = pc_q;
   assign pc_plus2 = pc_q + 16'd2;
   assign opcode   = fetch_word[15:11];
   assign is_halt  = (opcode == op_halt);
   assign is_ctrl  = (opcode[4:2] == cls_jump) || (opcode[4:2] == cls_branch);

   ////////////////////////////////////////
   // Source decode
   ////////////////////////////////////////

   always_comb begin
      query.src_a = fetch_word[10:8];
      query.src_b = fetch_word[7:5];
      // No rs for class 000, nor for the immediate jumps
      query.src_a_valid = (opcode[4:2] != cls_none) &&
                          !((opcode[4:2] == cls_jump) && !fetch_word[11]);
      // rt only for register-register forms
      query.src_b_valid = (opcode[4:1] == cls_rr_shift) ||
                          (opcode[4:2] == cls_alu_rr);
   end

   ////////////////////////////////////////
   // Shadow and halt FSM
   ////////////////////////////////////////

   always_comb begin
      state_d    = state;
      advance    = 1'b0;
      halt_issue = 1'b0;
      unique case (state)
         st_run: begin
            // A hazard holds the word in fetch
            if (!raw) begin
               advance = 1'b1;
               if (is_halt) begin
                  state_d    = st_halted;
                  halt_issue = 1'b1;
               end else if (is_ctrl) begin
                  state_d = shadow_entry;
               end
            end
         end
         st_shadow1: state_d = st_shadow2;
         st_shadow2: state_d = st_run;
         // Stuck until reset
         st_halted:  state_d = st_halted;
         default:    state_d = st_run;
      endcase
   end

   // Redirect wins over hold and increment, but not once halted
   always_comb begin
      if (redirect && (state != st_halted)) begin
         pc_d = redirect_pc;
      end else if (advance) begin
         pc_d = pc_plus2;
      end else begin
         pc_d = pc_q;
      end
   end

   // Bubble unless the fetched word goes out
   always_comb begin
      issue_d.instr   = advance ? fetch_word : bubble_word;
      issue_d.pc_next = pc_plus2;
   end

   ////////////////////////////////////////
   // Registers
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q          <= '0;
         state         <= st_run;
         issue.instr   <= bubble_word;
         issue.pc_next <= '0;
      end else begin
         pc_q  <= pc_d;
         state <= state_d;
         issue <= issue_d;
      end
   end

   // Halt pulse enters with the issue edge, dump follows dump_delay edges later
   always_ff @(posedge clk) begin
      if (reset) begin
         halt_line <= '0;
         dump      <= 1'b0;
      end else begin
         halt_line <= {halt_line[dump_delay-2:0], halt_issue};
         // Sticky
         dump      <= dump | halt_line[dump_delay-1];
      end
   end

endmodule

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 prog_we,
   input  fetch_pkg::mem_addr_t prog_addr,
   input  fetch_pkg::word_t     prog_data,
   input  logic                 redirect,
   input  fetch_pkg::word_t     redirect_pc,
   input  fetch_pkg::dst_t      dec_dst,
   output fetch_pkg::issue_t    issue,
   output logic                 dump
);

   import fetch_pkg::*;

   // Fetch address and the word it returns
   word_t pc;
   word_t fetch_word;

   // Hazard query and answer
   raw_query_t query;
   logic       raw;

   ////////////////////////////////////////
   // Instances
   ////////////////////////////////////////

   instr_mem u_instr_mem (
      .clk        (clk),
      .pc         (pc),
      .fetch_word (fetch_word),
      .prog_we    (prog_we),
      .prog_addr  (prog_addr),
      .prog_data  (prog_data)
   );

   // Decode destination goes straight in
   raw_detector u_raw_detector (
      .clk     (clk),
      .reset   (reset),
      .query   (query),
      .dec_dst (dec_dst),
      .raw     (raw)
   );

   fetch_stage u_fetch_stage (
      .clk         (clk),
      .reset       (reset),
      .fetch_word  (fetch_word),
      .pc          (pc),
      .query       (query),
      .raw         (raw),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .issue       (issue),
      .dump        (dump)
   );

endmodule

`default_nettype wire

//--- fetch_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_asserts (
   input logic                    clk,
   input logic                    reset,
   input fetch_pkg::word_t        pc,
   input fetch_pkg::fetch_state_t state,
   input fetch_pkg::issue_t       issue,
   input logic                    dump
);

   import fetch_pkg::*;

   // Failures so far, read from the testbench top
   int fail_count = 0;

   // Sticky dump, cleared only by reset
   dump_sticky: assert property (@(posedge clk) ($past(dump) && !dump) |-> $past(reset))
      else begin
         $error("dump fell while reset was low");
         fail_count++;
      end

   pc_even: assert property (@(posedge clk) disable iff (reset) !pc[0])
      else begin
         $error("pc is odd");
         fail_count++;
      end

   // Halted edge registers a bubble
   halted_bubble: assert property (@(posedge clk) disable iff (reset)
                                   (state == st_halted) |=> (issue.instr == bubble_word))
      else begin
         $error("non-bubble issued while halted");
         fail_count++;
      end

endmodule

bind fetch_stage fetch_asserts stage_asserts (
   .clk   (clk),
   .reset (reset),
   .pc    (pc),
   .state (state),
   .issue (issue),
   .dump  (dump)
);

`default_nettype wire

//--- fetch_checker.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_checker (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 prog_we,
   input  fetch_pkg::mem_addr_t prog_addr,
   input  fetch_pkg::word_t     prog_data,
   input  logic                 redirect,
   input  fetch_pkg::word_t     redirect_pc,
   input  fetch_pkg::dst_t      dec_dst,
   input  fetch_pkg::issue_t    issue,
   input  logic                 dump,
   output int                   error_count
);

   import fetch_pkg::*;

   // Program copy filled from the load port
   word_t mem_copy [mem_depth];

   // Model state
   word_t        pc_m;
   fetch_state_t state_m;
   dst_t         hist_m [hazard_window];
   int           halt_age;

   // Expected outputs after the last edge
   word_t exp_instr;
   word_t exp_pc_next;
   logic  exp_dump;

   int errors = 0;

   assign error_count = errors;

   ////////////////////////////////////////
   // Model
   ////////////////////////////////////////

   // One valid entry against the valid sources of w
   function automatic logic entry_hits(dst_t e, word_t w, logic a_ok, logic b_ok);
      return e.valid && ((a_ok && (e.dst == w[10:8])) || (b_ok && (e.dst == w[7:5])));
   endfunction

   task automatic step_model();
      word_t        w;
      logic         a_ok;
      logic         b_ok;
      logic         hazard;
      logic         halt_now;
      word_t        next_pc;
      fetch_state_t next_state;
      w = mem_copy[pc_m[8:1]];
      // rs absent for class 000 and for jumps with bit 11 clear
      a_ok = !((w[15:13] == 3'b000) || ((w[15:13] == 3'b001) && !w[11]));
      b_ok = (w[15:12] == 4'b1101) || (w[15:13] == 3'b111);
      // Live destination before the history
      hazard = entry_hits(dec_dst, w, a_ok, b_ok);
      for (int i = 0; i < hazard_window; i++) begin
         hazard = hazard | entry_hits(hist_m[i], w, a_ok, b_ok);
      end
      for (int i = hazard_window - 1; i > 0; i--) begin
         hist_m[i] = hist_m[i-1];
      end
      hist_m[0] = dec_dst;
      next_pc    = pc_m;
      next_state = state_m;
      halt_now   = 1'b0;
      exp_instr  = 16'h0800;
      case (state_m)
         st_shadow1: next_state = st_shadow2;
         st_shadow2: next_state = st_run;
         st_run: begin
            if (!hazard) begin
               exp_instr = w;
               next_pc   = pc_m + 16'd2;
               if (w[15:11] == 5'b00000) begin
                  next_state = st_halted;
                  halt_now   = 1'b1;
               end else if ((w[15:13] == 3'b001) || (w[15:13] == 3'b011)) begin
                  next_state = st_shadow1;
               end
            end
         end
         default: next_state = state_m;
      endcase
      // Redirect moves only the PC
      if (redirect && (state_m != st_halted)) begin
         next_pc = redirect_pc;
      end
      exp_pc_next = pc_m + 16'd2;
      // Count edges since the halt was issued
      if (halt_age >= 0) begin
         halt_age++;
      end
      if (halt_now) begin
         halt_age = 0;
      end
      if (halt_age >= dump_delay) begin
         exp_dump = 1'b1;
      end
      pc_m    = next_pc;
      state_m = next_state;
   endtask

   always @(posedge clk) begin
      if (reset) begin
         pc_m        = '0;
         state_m     = st_run;
         halt_age    = -1;
         exp_instr   = 16'h0800;
         exp_pc_next = '0;
         exp_dump    = 1'b0;
         for (int i = 0; i < hazard_window; i++) begin
            hist_m[i] = '0;
         end
      end else begin
         step_model();
      end
      // Write lands after this edge's read
      if (prog_we) begin
         mem_copy[prog_addr] = prog_data;
      end
   end

   ////////////////////////////////////////
   // Compare at mid cycle
   ////////////////////////////////////////

   task automatic compare(string name, logic [15:0] got, logic [15:0] exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   always @(negedge clk) begin
      compare("issue.instr", issue.instr, exp_instr);
      compare("issue.pc_next", issue.pc_next, exp_pc_next);
      compare("dump", {15'd0, dump}, {15'd0, exp_dump});
   end

endmodule

`default_nettype wire

//--- tb_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch;

   import fetch_pkg::*;

   localparam int num_phases = 4;
   localparam int run_cycles = 3000;
   // Full length of every phase at 4 ns, plus slack
   localparam int timeout_ns = num_phases * (run_cycles + 8 + mem_depth) * 4 + 2000;

   logic      clk;
   logic      reset;
   logic      prog_we;
   mem_addr_t prog_addr;
   word_t     prog_data;
   logic      redirect;
   word_t     redirect_pc;
   dst_t      dec_dst;
   issue_t    issue;
   logic      dump;
   int        checker_errors;
   int        halts = 0;

   fetch_top uut (
      .clk         (clk),
      .reset       (reset),
      .prog_we     (prog_we),
      .prog_addr   (prog_addr),
      .prog_data   (prog_data),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .dec_dst     (dec_dst),
      .issue       (issue),
      .dump        (dump)
   );

   fetch_checker u_checker (
      .clk         (clk),
      .reset       (reset),
      .prog_we     (prog_we),
      .prog_addr   (prog_addr),
      .prog_data   (prog_data),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .dec_dst     (dec_dst),
      .issue       (issue),
      .dump        (dump),
      .error_count (checker_errors)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   // Halts about 1 in 40, jumps and branches about 1 in 8
   function automatic word_t random_word();
      int pick;
      pick = $urandom_range(39, 0);
      if (pick == 0) begin
         return {5'b00000, 11'($urandom)};
      end else if (pick <= 5) begin
         return {($urandom_range(1, 0) == 0) ? 3'b001 : 3'b011, 13'($urandom)};
      end
      return 16'($urandom);
   endfunction

   task automatic load_program();
      @(posedge clk);
      #1;
      reset    = 1'b1;
      redirect = 1'b0;
      dec_dst  = '0;
      for (int a = 0; a < mem_depth; a++) begin
         prog_we   = 1'b1;
         prog_addr = mem_addr_t'(a);
         prog_data = random_word();
         @(posedge clk);
         #1;
      end
      prog_we = 1'b0;
      repeat (8) begin
         @(posedge clk);
         #1;
      end
      reset = 1'b0;
   endtask

   // New inputs, then one edge
   task automatic drive_cycle();
      redirect      = ($urandom_range(5, 0) == 0);
      redirect_pc   = 16'($urandom) & 16'hfffe;
      dec_dst.dst   = 3'($urandom);
      dec_dst.valid = 1'($urandom);
      @(posedge clk);
      #1;
   endtask

   // Ends early once dump is up
   task automatic run_phase();
      int n;
      n = 0;
      while ((n < run_cycles) && !dump) begin
         drive_cycle();
         n++;
      end
      if (dump) begin
         halts++;
         // Dump has to hold
         repeat (6) drive_cycle();
      end
      redirect = 1'b0;
   endtask

   initial begin
      int total;
      void'($urandom(38));
      reset       = 1'b1;
      prog_we     = 1'b0;
      prog_addr   = '0;
      prog_data   = '0;
      redirect    = 1'b0;
      redirect_pc = '0;
      dec_dst     = '0;
      for (int p = 0; p < num_phases; p++) begin
         load_program();
         run_phase();
      end
      total = checker_errors + uut.u_fetch_stage.stage_asserts.fail_count;
      $display("Errors: %0d from the model, %0d from assertions, %0d halts in %0d phases",
               checker_errors, uut.u_fetch_stage.stage_asserts.fail_count, halts, num_phases);
      if (total == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   ////////////////////////////////////////
   // Watchdog
   ////////////////////////////////////////

   initial begin
      #(timeout_ns);
      $display("Timeout: the run did not finish within %0d ns", timeout_ns);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- fetch_top.f
fetch_pkg.sv
instr_mem.sv
raw_detector.sv
fetch_stage.sv
fetch_top.sv
fetch_asserts.sv
fetch_checker.sv
tb_fetch.sv

//--- Makefile
SRCS := $(shell cat fetch_top.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_fetch: $(SRCS) fetch_top.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch -f fetch_top.f -o Vtb_fetch

run: obj_dir/Vtb_fetch
	./obj_dir/Vtb_fetch +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
